/* floo_macros.svh */
// Mesh router build constants
// Port count, coordinate and payload widths and mesh size for one router node

`ifndef FLOO_MACROS_SVH
`define FLOO_MACROS_SVH

// North, East, South, West and the local Eject/Inject port
`define FLOO_NUM_ROUTES 5

// Width of each of the x and y coordinate fields
`define FLOO_COORD_W 3

// Flit payload width
`define FLOO_PAYLOAD_W 32

// Nodes per mesh axis
`define FLOO_MESH_DIM 4

`endif

/* floo_pkg.sv */
// Mesh router types
// Node coordinate, output direction and single-flit packet format

`include "floo_macros.svh"

package floo_pkg;

  // Node position in the mesh
  typedef struct packed {
    logic [`FLOO_COORD_W-1:0] x;
    logic [`FLOO_COORD_W-1:0] y;
  } coord_t;

  // Output direction, the value doubles as the port index
  typedef enum logic [2:0] {
    DIR_NORTH = 3'd0,
    DIR_EAST  = 3'd1,
    DIR_SOUTH = 3'd2,
    DIR_WEST  = 3'd3,
    DIR_EJECT = 3'd4
  } route_dir_e;

  // One packet is one flit
  typedef struct packed {
    coord_t                     dst;
    route_dir_e                 src_port;
    logic [`FLOO_PAYLOAD_W-1:0] payload;
  } flit_t;

endpackage

/* floo_link_if.sv */
// Router internal link
// Per-route valid/ready handshake with the flit and its routed direction

`timescale 1ns/1ps

`include "floo_macros.svh"

interface floo_link_if import floo_pkg::*; ();

  logic       [`FLOO_NUM_ROUTES-1:0] valid;
  logic       [`FLOO_NUM_ROUTES-1:0] ready;
  flit_t      [`FLOO_NUM_ROUTES-1:0] flit;
  route_dir_e [`FLOO_NUM_ROUTES-1:0] dir;

  // Sending side of the link
  modport upstream (output valid, output flit, output dir, input ready);

  // Receiving side of the link
  modport downstream (input valid, input flit, input dir, output ready);

endinterface

/* floo_route_stage.sv */
// Router input stage
// Registers one flit per input port together with its XY output direction

`timescale 1ns/1ps

`include "floo_macros.svh"

module floo_route_stage import floo_pkg::*; (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  input  coord_t                            id_i,
  input  logic   [`FLOO_NUM_ROUTES-1:0]     flit_valid_i,
  input  flit_t  [`FLOO_NUM_ROUTES-1:0]     flit_i,
  output logic   [`FLOO_NUM_ROUTES-1:0]     flit_ready_o,
  floo_link_if.upstream                     link
);

  logic       [`FLOO_NUM_ROUTES-1:0] vld_q;
  flit_t      [`FLOO_NUM_ROUTES-1:0] flit_q;
  route_dir_e [`FLOO_NUM_ROUTES-1:0] dir_q;

  // Dimension-ordered routing, x is resolved first
  function automatic route_dir_e xy_route(coord_t dst, coord_t id);
    route_dir_e dir;
    if (dst.x > id.x) begin
      dir = DIR_EAST;
    end else if (dst.x < id.x) begin
      dir = DIR_WEST;
    end else if (dst.y > id.y) begin
      dir = DIR_NORTH;
    end else if (dst.y < id.y) begin
      dir = DIR_SOUTH;
    end else begin
      dir = DIR_EJECT;
    end
    return dir;
  endfunction

  for (genvar i = 0; i < `FLOO_NUM_ROUTES; i++) begin : gen_in
    // Free when empty or when the held flit is taken this cycle
    assign flit_ready_o[i] = !vld_q[i] || link.ready[i];

    always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
        vld_q[i] <= 1'b0;
      end else if (flit_ready_o[i]) begin
        vld_q[i] <= flit_valid_i[i];
      end
    end

    always_ff @(posedge clk_i) begin
      if (flit_valid_i[i] && flit_ready_o[i]) begin
        flit_q[i] <= flit_i[i];
        dir_q[i]  <= xy_route(flit_i[i].dst, id_i);
      end
    end
  end

  assign link.valid = vld_q;
  assign link.flit  = flit_q;
  assign link.dir   = dir_q;

endmodule

/* floo_switch_arb.sv */
// Router switch allocator and crossbar
// Each output picks one requesting input round-robin and forwards its flit

`timescale 1ns/1ps

`include "floo_macros.svh"

module floo_switch_arb import floo_pkg::*; (
  input  logic            clk_i,
  input  logic            rst_n_i,
  floo_link_if.downstream in_link,
  floo_link_if.upstream   out_link
);

  localparam int NR    = `FLOO_NUM_ROUTES;
  localparam int IDX_W = $clog2(NR);

  // Inputs that hand over their flit this cycle, one vector per output
  logic [NR-1:0] xfer_oh [NR];

  for (genvar o = 0; o < NR; o++) begin : gen_out
    logic [NR-1:0]    req;
    logic             gnt_vld;
    logic [IDX_W-1:0] gnt_idx;
    logic [IDX_W-1:0] ptr_q;
    logic             xfer;

    always_comb begin
      for (int i = 0; i < NR; i++) begin
        req[i] = in_link.valid[i] && (in_link.dir[i] == route_dir_e'(o));
      end
    end

    // First requester at or after the pointer, wrapping around
    always_comb begin : pick
      int unsigned idx;
      idx     = 0;
      gnt_vld = 1'b0;
      gnt_idx = '0;
      for (int k = 0; k < NR; k++) begin
        idx = ptr_q + k;
        if (idx >= NR) begin
          idx = idx - NR;
        end
        if (!gnt_vld && req[idx]) begin
          gnt_vld = 1'b1;
          gnt_idx = IDX_W'(idx);
        end
      end
    end

    assign xfer        = gnt_vld && out_link.ready[o];
    assign xfer_oh[o]  = xfer ? (NR'(1) << gnt_idx) : '0;

    assign out_link.valid[o] = gnt_vld;
    assign out_link.flit[o]  = in_link.flit[gnt_idx];
    assign out_link.dir[o]   = route_dir_e'(o);

    // Advance past the winner on transfer, park on it while blocked
    // so the offered flit stays put until the output frees up
    always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
        ptr_q <= '0;
      end else if (xfer) begin
        ptr_q <= (gnt_idx == IDX_W'(NR-1)) ? '0 : gnt_idx + 1'b1;
      end else if (gnt_vld) begin
        ptr_q <= gnt_idx;
      end
    end
  end

  // An input is released only by the output that took its flit
  always_comb begin
    in_link.ready = '0;
    for (int o = 0; o < NR; o++) begin
      in_link.ready = in_link.ready | xfer_oh[o];
    end
  end

endmodule

/* floo_out_stage.sv */
// Router output stage
// Registers one flit per output port toward the outgoing links

`timescale 1ns/1ps

`include "floo_macros.svh"

module floo_out_stage import floo_pkg::*; (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  floo_link_if.downstream               link,
  output logic  [`FLOO_NUM_ROUTES-1:0]  flit_valid_o,
  output flit_t [`FLOO_NUM_ROUTES-1:0]  flit_o,
  input  logic  [`FLOO_NUM_ROUTES-1:0]  flit_ready_i
);

  logic  [`FLOO_NUM_ROUTES-1:0] vld_q;
  flit_t [`FLOO_NUM_ROUTES-1:0] flit_q;

  for (genvar o = 0; o < `FLOO_NUM_ROUTES; o++) begin : gen_out
    // Take a new flit when empty or when the current one leaves
    assign link.ready[o] = !vld_q[o] || flit_ready_i[o];

    always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
        vld_q[o] <= 1'b0;
      end else if (link.ready[o]) begin
        vld_q[o] <= link.valid[o];
      end
    end

    always_ff @(posedge clk_i) begin
      if (link.valid[o] && link.ready[o]) begin
        flit_q[o] <= link.flit[o];
      end
    end
  end

  assign flit_valid_o = vld_q;
  assign flit_o       = flit_q;

endmodule

/* floo_mesh_router.sv */
// Five-port 2D mesh router with XY routing
// Route stage, round-robin switch and output stage on valid/ready links

`timescale 1ns/1ps

`include "floo_macros.svh"

module floo_mesh_router import floo_pkg::*; (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  // Position of this node in the mesh
  input  coord_t                        id_i,
  // Incoming links
  input  logic  [`FLOO_NUM_ROUTES-1:0]  flit_valid_i,
  input  flit_t [`FLOO_NUM_ROUTES-1:0]  flit_i,
  output logic  [`FLOO_NUM_ROUTES-1:0]  flit_ready_o,
  // Outgoing links
  output logic  [`FLOO_NUM_ROUTES-1:0]  flit_valid_o,
  output flit_t [`FLOO_NUM_ROUTES-1:0]  flit_o,
  input  logic  [`FLOO_NUM_ROUTES-1:0]  flit_ready_i
);

  floo_link_if route_link ();
  floo_link_if out_link ();

  floo_route_stage i_route_stage (
    .clk_i        ( clk_i        ),
    .rst_n_i      ( rst_n_i      ),
    .id_i         ( id_i         ),
    .flit_valid_i ( flit_valid_i ),
    .flit_i       ( flit_i       ),
    .flit_ready_o ( flit_ready_o ),
    .link         ( route_link   )
  );

  floo_switch_arb i_switch_arb (
    .clk_i    ( clk_i      ),
    .rst_n_i  ( rst_n_i    ),
    .in_link  ( route_link ),
    .out_link ( out_link   )
  );

  floo_out_stage i_out_stage (
    .clk_i        ( clk_i        ),
    .rst_n_i      ( rst_n_i      ),
    .link         ( out_link     ),
    .flit_valid_o ( flit_valid_o ),
    .flit_o       ( flit_o       ),
    .flit_ready_i ( flit_ready_i )
  );

endmodule

/* floo_router_chk.sv */
// Mesh router port checker
// Concurrent assertions on reset, XY direction, back-pressure and latency

`timescale 1ns/1ps

`include "floo_macros.svh"

module floo_router_chk import floo_pkg::*; (
  input logic                         clk_i,
  input logic                         rst_n_i,
  input coord_t                       id_i,
  input logic  [`FLOO_NUM_ROUTES-1:0] flit_valid_i,
  input logic  [`FLOO_NUM_ROUTES-1:0] flit_ready_o,
  input logic  [`FLOO_NUM_ROUTES-1:0] flit_valid_o,
  input flit_t [`FLOO_NUM_ROUTES-1:0] flit_o,
  input logic  [`FLOO_NUM_ROUTES-1:0] flit_ready_i
);

  int unsigned fail_cnt = 0;
  logic [3:0]  inflight_q;
  logic        lone_accept;

  // Output o may only carry flits that XY routing sends there
  function automatic logic on_xy_path(int o, coord_t dst, coord_t id);
    logic ok;
    case (route_dir_e'(o))
      DIR_NORTH: ok = (dst.x == id.x) && (dst.y > id.y);
      DIR_SOUTH: ok = (dst.x == id.x) && (dst.y < id.y);
      DIR_EAST:  ok = dst.x > id.x;
      DIR_WEST:  ok = dst.x < id.x;
      default:   ok = (dst == id);
    endcase
    return ok;
  endfunction

  // Flits inside the router, accepted minus delivered
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      inflight_q <= '0;
    end else begin
      inflight_q <= inflight_q + 4'($countones(flit_valid_i & flit_ready_o))
                               - 4'($countones(flit_valid_o & flit_ready_i));
    end
  end

  // One flit entering an empty router
  assign lone_accept = (inflight_q == '0) && $onehot(flit_valid_i & flit_ready_o);

  reset_quiet: assert property (@(posedge clk_i) !rst_n_i |=> flit_valid_o == '0)
    else begin
      $error("flit_valid_o high during reset or in the first cycle after it");
      fail_cnt++;
    end

  two_cycle_latency: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $past(lone_accept, 2) |-> ($past(flit_valid_o) == '0) && $onehot(flit_valid_o))
    else begin
      $error("lone flit did not reach its output two cycles after acceptance");
      fail_cnt++;
    end

  for (genvar o = 0; o < `FLOO_NUM_ROUTES; o++) begin : gen_port
    xy_dir: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      flit_valid_o[o] |-> on_xy_path(o, flit_o[o].dst, id_i))
      else begin
        $error("flit on output %0d breaks the XY routing rule", o);
        fail_cnt++;
      end

    hold_on_stall: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      flit_valid_o[o] && !flit_ready_i[o] |=> flit_valid_o[o] && $stable(flit_o[o]))
      else begin
        $error("output %0d changed while stalled", o);
        fail_cnt++;
      end
  end

endmodule

bind floo_mesh_router floo_router_chk i_router_chk (
  .clk_i        ( clk_i        ),
  .rst_n_i      ( rst_n_i      ),
  .id_i         ( id_i         ),
  .flit_valid_i ( flit_valid_i ),
  .flit_ready_o ( flit_ready_o ),
  .flit_valid_o ( flit_valid_o ),
  .flit_o       ( flit_o       ),
  .flit_ready_i ( flit_ready_i )
);

/* tb_floo_mesh_router.sv */
// Mesh router testbench
// XY-legal random traffic on all ports, per-pair scoreboard and Eject fairness check

`timescale 1ns/1ps

`include "floo_macros.svh"

module tb_floo_mesh_router import floo_pkg::*; ();

  localparam int     NR          = `FLOO_NUM_ROUTES;
  localparam int     CLK_PERIOD  = 40;
  localparam int     LAT_FLITS   = 8;
  localparam int     TRAFFIC_CYC = 200;
  localparam int     FAIR_CYC    = 100;
  localparam int     DRAIN_CYC   = 60;
  localparam int     TOTAL_CYC   = 10 + (LAT_FLITS + 3) * DRAIN_CYC + 2 * TRAFFIC_CYC + FAIR_CYC;
  localparam coord_t NODE_ID     = '{x: 3'd1, y: 3'd2};

  logic           clk_i;
  logic           rst_n_i;
  logic  [NR-1:0] flit_valid_i;
  flit_t [NR-1:0] flit_i;
  logic  [NR-1:0] flit_ready_o;
  logic  [NR-1:0] flit_valid_o;
  flit_t [NR-1:0] flit_o;
  logic  [NR-1:0] flit_ready_i;

  // Expected flits per input and output pair, oldest first
  flit_t          sb_q [NR][NR][$];
  logic  [NR-1:0] acc = '0;
  int             err_cnt = 0;
  int             mark = 0;
  int             tests_run = 0;
  int             tests_failed = 0;
  logic           fair_chk = 1'b0;
  logic           have_last = 1'b0;
  route_dir_e     last_src = DIR_NORTH;

  floo_mesh_router i_dut (
    .clk_i        ( clk_i        ),
    .rst_n_i      ( rst_n_i      ),
    .id_i         ( NODE_ID      ),
    .flit_valid_i ( flit_valid_i ),
    .flit_i       ( flit_i       ),
    .flit_ready_o ( flit_ready_o ),
    .flit_valid_o ( flit_valid_o ),
    .flit_o       ( flit_o       ),
    .flit_ready_i ( flit_ready_i )
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // Output picked by XY routing, x settles before y
  function automatic route_dir_e expected_port(coord_t dst);
    route_dir_e port;
    port = DIR_EJECT;
    if (dst.y != NODE_ID.y) begin
      port = (dst.y > NODE_ID.y) ? DIR_NORTH : DIR_SOUTH;
    end
    if (dst.x != NODE_ID.x) begin
      port = (dst.x > NODE_ID.x) ? DIR_EAST : DIR_WEST;
    end
    return port;
  endfunction

  // Mesh inputs never turn back, and North or South inputs only go straight or eject
  // Local flits may go anywhere including this node
  function automatic logic legal_for(route_dir_e port, coord_t dst);
    route_dir_e out;
    logic       ok;
    out = expected_port(dst);
    case (port)
      DIR_NORTH: ok = out inside {DIR_SOUTH, DIR_EJECT};
      DIR_SOUTH: ok = out inside {DIR_NORTH, DIR_EJECT};
      DIR_EJECT: ok = 1'b1;
      default:   ok = (out != port);
    endcase
    return ok;
  endfunction

  function automatic flit_t make_flit(route_dir_e port, logic to_eject);
    flit_t f;
    f.src_port = port;
    f.payload  = $urandom;
    f.dst      = NODE_ID;
    if (!to_eject) begin
      do begin
        f.dst.x = 3'($urandom_range(`FLOO_MESH_DIM - 1, 0));
        f.dst.y = 3'($urandom_range(`FLOO_MESH_DIM - 1, 0));
      end while (!legal_for(port, f.dst));
    end
    return f;
  endfunction

  function automatic int outstanding();
    int n;
    n = 0;
    for (int i = 0; i < NR; i++) begin
      for (int o = 0; o < NR; o++) begin
        n += sb_q[i][o].size();
      end
    end
    return n;
  endfunction

  function automatic int total_errors();
    return err_cnt + int'(i_dut.i_router_chk.fail_cnt);
  endfunction

  task automatic check_delivery(int o, flit_t f);
    flit_t exp_f;
    int    s;
    s = int'(f.src_port);
    assert (s < NR && sb_q[s][o].size() > 0)
      else begin
        $display("ERROR %0t: unexpected flit on output %0d from port %0d", $time, o, s);
        err_cnt++;
      end
    if (s < NR && sb_q[s][o].size() > 0) begin
      exp_f = sb_q[s][o].pop_front();
      assert (f == exp_f)
        else begin
          $display("ERROR %0t: output %0d got %h, expected %h", $time, o, f, exp_f);
          err_cnt++;
        end
    end
    if (fair_chk && o == int'(DIR_EJECT)) begin
      assert (!have_last || f.src_port != last_src)
        else begin
          $display("ERROR %0t: Eject granted port %0d twice in a row", $time, s);
          err_cnt++;
        end
      have_last = 1'b1;
      last_src  = f.src_port;
    end
  endtask

  // Handshakes are stable mid-cycle, well away from both edges
  always @(negedge clk_i) begin
    if (rst_n_i) begin
      for (int i = 0; i < NR; i++) begin
        acc[i] = flit_valid_i[i] && flit_ready_o[i];
        if (acc[i]) begin
          sb_q[i][expected_port(flit_i[i].dst)].push_back(flit_i[i]);
        end
      end
      for (int o = 0; o < NR; o++) begin
        if (flit_valid_o[o] && flit_ready_i[o]) begin
          check_delivery(o, flit_o[o]);
        end
      end
    end
  end

  // A source offers a new flit only once the old one was taken
  task automatic step(logic [NR-1:0] en, logic stall, logic to_eject);
    for (int i = 0; i < NR; i++) begin
      if (!flit_valid_i[i] || acc[i]) begin
        flit_valid_i[i] = en[i];
        if (en[i]) begin
          flit_i[i] = make_flit(route_dir_e'(i), to_eject);
        end
      end
    end
    flit_ready_i = stall ? NR'($urandom) : '1;
    @(posedge clk_i);
    #1;
  endtask

  task automatic drain();
    int n;
    n = 0;
    while ((flit_valid_i != '0 || outstanding() != 0) && n < DRAIN_CYC) begin
      step('0, 1'b0, 1'b0);
      n++;
    end
    assert (flit_valid_i == '0)
      else begin
        $display("Router stopped accepting flits on inputs %b", flit_valid_i);
        err_cnt++;
      end
    assert (outstanding() == 0)
      else begin
        $display("Router never delivered %0d accepted flits", outstanding());
        err_cnt++;
      end
  endtask

  task automatic report(string name);
    int errs;
    errs = total_errors() - mark;
    mark = total_errors();
    tests_run++;
    if (errs != 0) begin
      tests_failed++;
    end
    $display("Test %s: %s, %0d errors", name, (errs == 0) ? "passed" : "failed", errs);
  endtask

  initial begin
    void'($urandom(32'hbe6abd76));
    rst_n_i      = 1'b0;
    flit_valid_i = '0;
    flit_i       = '0;
    flit_ready_i = '1;
    repeat (10) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;
    step('0, 1'b0, 1'b0);
    report("reset");

    // One local flit at a time through an idle router
    repeat (LAT_FLITS) begin
      step(NR'(1) << DIR_EJECT, 1'b0, 1'b0);
      drain();
    end
    report("latency");

    repeat (TRAFFIC_CYC) step('1, 1'b0, 1'b0);
    drain();
    report("random");

    repeat (TRAFFIC_CYC) step('1, 1'b1, 1'b0);
    drain();
    report("stall");

    // North and South compete for Eject every cycle
    fair_chk = 1'b1;
    repeat (FAIR_CYC) step((NR'(1) << DIR_NORTH) | (NR'(1) << DIR_SOUTH), 1'b0, 1'b1);
    drain();
    fair_chk = 1'b0;
    report("fairness");

    $display("Tests: %0d passed, %0d failed, %0d errors", tests_run - tests_failed,
             tests_failed, total_errors());
    if (total_errors() == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  initial begin
    #(CLK_PERIOD * (TOTAL_CYC + 100));
    $display("Timeout: the tests did not finish within %0d cycles", TOTAL_CYC + 100);
    $display("Done: errors found");
    $finish;
  end

endmodule

/* sources.f */
+incdir+.
floo_pkg.sv
floo_link_if.sv
floo_route_stage.sv
floo_switch_arb.sv
floo_out_stage.sv
floo_mesh_router.sv
floo_router_chk.sv
tb_floo_mesh_router.sv

/* run_sim.sh */
#!/bin/sh
# Build the mesh router testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f \
  --top-module tb_floo_mesh_router --Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/sim_tb +verilator+error+limit+1000)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "Done: no errors"; then
  exit 0
fi
echo "Pass message not found in the simulation output"
exit 1
